//--- sim.f
source/riscv_isa_pkg.sv
source/core_ctrl_pkg.sv
source/control_fsm.sv
source/instr_decode.sv
source/reg_file.sv
source/alu.sv
source/mem_access.sv
source/multicycle_core.sv
verification/tb_memory.sv
verification/tb_multicycle_core.sv

//--- Makefile
TOP = tb_multicycle_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

//--- verification/tb_multicycle_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_multicycle_core
  import riscv_isa_pkg::*;
  ;

  localparam int    DATA_OFF  = 'h400;  // Result words, one per check
  localparam int    DATA_IDX  = 'h400 / 4;
  localparam int    DONE_OFF  = 'h7FC;
  localparam addr_t DONE_ADDR = 32'h0000_07FC;
  localparam int    TIMEOUT   = 2000;

  logic       clk;
  logic       rst_n;
  addr_t      mem_address;
  data_t      mem_write_data;
  logic [3:0] mem_write_enable;
  data_t      mem_read_data;
  logic       load_en;
  logic [9:0] load_addr;
  data_t      load_data;

  data_t       image [1024];  // Memory contents built by each test
  int          pc_word;
  data_t       exp_q [$];
  logic [31:0] rng;

  multicycle_core i_dut
    ( .clk              ( clk              )
    , .rst_n            ( rst_n            )
    , .mem_address      ( mem_address      )
    , .mem_write_data   ( mem_write_data   )
    , .mem_write_enable ( mem_write_enable )
    , .mem_read_data    ( mem_read_data    )
    );

  tb_memory #(.WORDS(1024)) i_mem
    ( .clk          ( clk              )
    , .address      ( mem_address      )
    , .write_data   ( mem_write_data   )
    , .write_enable ( mem_write_enable )
    , .read_data    ( mem_read_data    )
    , .load_en      ( load_en          )
    , .load_addr    ( load_addr        )
    , .load_data    ( load_data        )
    );

  always #5 clk = ~clk;

  function automatic instr_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                    input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_R};
  endfunction

  function automatic instr_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input opcode_t op);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
  endfunction

  function automatic instr_t s_type(input int imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], OP_STORE};
  endfunction

  function automatic instr_t b_type(input int imm, input int rs2, input int rs1,
                                    input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic instr_t j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  function automatic instr_t u_type(input int imm, input int rd);
    return {imm[19:0], rd[4:0], OP_LUI};
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t sext_byte(input logic [7:0] b);
    return {{24{b[7]}}, b};
  endfunction

  function automatic data_t sext_imm(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_eq(input data_t got, input data_t expected, input string what);
    assert (got === expected) else begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      abort_run();
    end
  endtask

  task automatic start_program();
    for (int i = 0; i < 1024; i++) begin
      image[i] = 32'hC0DE_0000 ^ (data_t'(i) << 2);  // Fill tied to the address
    end
    pc_word = 0;
    exp_q.delete();
  endtask

  task automatic emit(input instr_t w);
    image[pc_word] = w;
    pc_word++;
  endtask

  // Store register rs into the next result word and remember its expected value
  task automatic store_expect(input int rs, input data_t value);
    emit(s_type(DATA_OFF + 4 * exp_q.size(), rs, 0, F3_WORD));
    exp_q.push_back(value);
  endtask

  task automatic finish_program();
    emit(s_type(DONE_OFF, 0, 0, F3_WORD));
    emit(j_type(0, 0));  // Park the core
  endtask

  task automatic load_and_reset();
    rst_n = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      load_en   = 1'b1;
      load_addr = i[9:0];
      load_data = image[i];
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    repeat (3) begin
      @(posedge clk);
      #1;
      check_eq({28'h0, mem_write_enable}, 32'h0, "write enable in reset");
      check_eq(mem_address, RESET_PC, "address in reset");
    end
    rst_n = 1'b1;
    @(posedge clk);  // First cycle after release must not advance the PC
    #1;
    check_eq({28'h0, mem_write_enable}, 32'h0, "write enable after reset");
    check_eq(mem_address, RESET_PC, "address after reset");
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (!(mem_write_enable != 4'b0 && mem_address == DONE_ADDR)) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("Timeout at %0t ns: the program never signalled completion", $time);
        abort_run();
      end
    end
    @(posedge clk);
    #1;
  endtask

  task automatic run_and_check(input string name);
    load_and_reset();
    wait_done();
    foreach (exp_q[k]) begin
      check_eq(i_mem.words[DATA_IDX + k], exp_q[k], $sformatf("%s result %0d", name, k));
    end
  endtask

  task automatic x0_after_reset();
    start_program();
    emit(i_type(123, 0, F3_ADD_SUB, 0, OP_IMM));  // addi x0 must be dropped
    store_expect(0, 32'h0);
    finish_program();
    run_and_check("reset");
  endtask

  task automatic alu_operations();
    data_t a;
    data_t b;
    a = 32'hFFFF_FFEC;  // -20
    b = 32'd7;
    start_program();
    emit(i_type(-20, 0, F3_ADD_SUB, 1, OP_IMM));
    emit(i_type(7, 0, F3_ADD_SUB, 2, OP_IMM));
    emit(i_type(37, 0, F3_ADD_SUB, 3, OP_IMM));  // Shift amount masks to 5
    emit(r_type(7'h00, 2, 1, F3_ADD_SUB, 10));
    store_expect(10, a + b);
    emit(r_type(7'h20, 2, 1, F3_ADD_SUB, 10));
    store_expect(10, a - b);
    emit(r_type(7'h00, 2, 1, F3_AND, 10));
    store_expect(10, a & b);
    emit(r_type(7'h00, 2, 1, F3_OR, 10));
    store_expect(10, a | b);
    emit(r_type(7'h00, 2, 1, F3_XOR, 10));
    store_expect(10, a ^ b);
    emit(r_type(7'h00, 2, 1, F3_SLT, 10));
    store_expect(10, 32'd1);  // -20 < 7
    emit(r_type(7'h00, 1, 2, F3_SLT, 10));
    store_expect(10, 32'd0);
    emit(r_type(7'h00, 3, 2, F3_SLL, 10));
    store_expect(10, 32'h0000_00E0);  // 7 << 5
    emit(r_type(7'h00, 3, 1, F3_SRL, 10));
    store_expect(10, 32'h07FF_FFFF);  // Logical, no sign fill
    emit(i_type(-5, 1, F3_ADD_SUB, 10, OP_IMM));
    store_expect(10, a + sext_imm(12'hFFB));
    emit(i_type('h0F0, 1, F3_AND, 10, OP_IMM));
    store_expect(10, a & sext_imm(12'h0F0));
    emit(i_type(-256, 2, F3_OR, 10, OP_IMM));
    store_expect(10, b | sext_imm(12'hF00));
    emit(i_type('h555, 1, F3_XOR, 10, OP_IMM));
    store_expect(10, a ^ sext_imm(12'h555));
    emit(i_type(-19, 1, F3_SLT, 10, OP_IMM));
    store_expect(10, 32'd1);  // -20 < -19
    emit(i_type(-1, 2, F3_SLT, 10, OP_IMM));
    store_expect(10, 32'd0);
    finish_program();
    run_and_check("alu");
  endtask

  task automatic byte_and_word_access();
    data_t sb_exp [4];
    data_t src;
    start_program();
    image['h500 / 4] = 32'h7F80_C311;
    src = image['h500 / 4];
    for (int k = 0; k < 4; k++) begin
      sb_exp[k] = image['h600 / 4 + k];
      sb_exp[k][k*8 +: 8] = 8'hA5;  // Only the addressed lane changes
    end
    emit(i_type('hA5, 0, F3_ADD_SUB, 5, OP_IMM));
    for (int k = 0; k < 4; k++) begin
      emit(s_type('h600 + 4 * k + k, 5, 0, F3_BYTE));
    end
    emit(i_type('h501, 0, F3_BYTE, 7, OP_LOAD));
    store_expect(7, sext_byte(src[15:8]));
    emit(i_type('h501, 0, F3_BYTE_U, 8, OP_LOAD));
    store_expect(8, {24'h0, src[15:8]});
    emit(i_type('h502, 0, F3_BYTE, 9, OP_LOAD));
    store_expect(9, sext_byte(src[23:16]));
    emit(i_type('h503, 0, F3_BYTE, 9, OP_LOAD));
    store_expect(9, sext_byte(src[31:24]));
    emit(i_type(-1234, 0, F3_ADD_SUB, 6, OP_IMM));
    emit(s_type('h540, 6, 0, F3_WORD));
    emit(i_type('h540, 0, F3_WORD, 11, OP_LOAD));
    store_expect(11, sext_imm(12'hB2E));  // -1234
    finish_program();
    run_and_check("mem");
    for (int k = 0; k < 4; k++) begin
      check_eq(i_mem.words['h600 / 4 + k], sb_exp[k], $sformatf("sb offset %0d", k));
    end
  endtask

  task automatic branch_and_jump();
    data_t jal_addr;
    start_program();
    emit(i_type(7, 0, F3_ADD_SUB, 1, OP_IMM));
    emit(r_type(7'h00, 1, 2, F3_ADD_SUB, 2));  // Loop body
    emit(i_type(-1, 1, F3_ADD_SUB, 1, OP_IMM));
    emit(b_type(-8, 0, 1, F3_BNE));
    store_expect(2, 32'd28);
    emit(i_type(1, 0, F3_ADD_SUB, 3, OP_IMM));
    emit(b_type(8, 0, 3, F3_BEQ));  // Not taken
    emit(i_type(55, 0, F3_ADD_SUB, 4, OP_IMM));
    store_expect(4, 32'd55);
    jal_addr = pc_word * 4;
    emit(j_type(8, 5));
    emit(i_type(99, 0, F3_ADD_SUB, 6, OP_IMM));  // Skipped
    store_expect(5, jal_addr + 32'd4);
    store_expect(6, 32'd0);
    finish_program();
    run_and_check("flow");
  endtask

  task automatic lui_random_arith();
    data_t vals [10];
    data_t upper;
    data_t v;
    start_program();
    for (int k = 0; k < 10; k++) begin
      rng = xorshift(rng);
      v = rng;
      upper = (v + 32'h800) >> 12;  // Undo the sign of the low part
      emit(u_type(int'(upper), k + 1));
      emit(i_type(int'(v), k + 1, F3_ADD_SUB, k + 1, OP_IMM));
      vals[k] = v;  // lui plus addi rebuild the whole constant
      store_expect(k + 1, vals[k]);
    end
    for (int k = 0; k < 9; k++) begin
      emit(r_type(7'h00, k + 2, k + 1, F3_ADD_SUB, 11));
      store_expect(11, vals[k] + vals[k+1]);
      emit(r_type(7'h20, k + 2, k + 1, F3_ADD_SUB, 11));
      store_expect(11, vals[k] - vals[k+1]);
      emit(r_type(7'h00, k + 2, k + 1, F3_XOR, 11));
      store_expect(11, vals[k] ^ vals[k+1]);
    end
    finish_program();
    run_and_check("lui_rand");
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    rng       = 32'd18881;
    x0_after_reset();
    alu_operations();
    byte_and_word_access();
    branch_and_jump();
    lui_random_arith();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory
  import riscv_isa_pkg::*;
  #( parameter int WORDS = 1024
  , localparam int AW = $clog2(WORDS)
  )
  ( input  logic          clk
  , input  addr_t         address
  , input  data_t         write_data
  , input  logic [3:0]    write_enable
  , output data_t         read_data
  , input  logic          load_en
  , input  logic [AW-1:0] load_addr
  , input  data_t         load_data
  );

  data_t words [WORDS];

  assign read_data = words[address[AW+1:2]];  // Same-cycle read

  always @(posedge clk) begin
    if (load_en) begin  // Preload port used only while the core is in reset
      words[load_addr] <= load_data;
    end else begin
      for (int lane = 0; lane < 4; lane++) begin
        if (write_enable[lane]) begin
          words[address[AW+1:2]][lane*8 +: 8] <= write_data[lane*8 +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- source/multicycle_core.sv
`timescale 1ns/1ps
`default_nettype none

module multicycle_core
  import riscv_isa_pkg::*, core_ctrl_pkg::*;
  ( input  logic       clk
  , input  logic       rst_n
  , output addr_t      mem_address
  , output data_t      mem_write_data
  , output logic [3:0] mem_write_enable
  , input  data_t      mem_read_data
  );

  logic        pc_update;
  logic        ir_write;
  logic        reg_write;
  logic        mem_write;
  adr_src_t    adr_src;
  alu_src_a_t  alu_src_a;
  alu_src_b_t  alu_src_b;
  result_src_t result_src;
  alu_mode_t   alu_mode;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  data_t      imm_ext;
  alu_op_t    alu_op;

  addr_t  pc;
  addr_t  old_pc;
  instr_t instr;
  data_t  data_reg;
  data_t  data_a;
  data_t  data_b;
  data_t  alu_out;
  data_t  rd1;
  data_t  rd2;
  data_t  alu_a;
  data_t  alu_b;
  data_t  alu_result;
  logic   zero;
  data_t  load_data;
  data_t  result;

  control_fsm i_control_fsm
    ( .clk        ( clk        )
    , .rst_n      ( rst_n      )
    , .opcode     ( opcode     )
    , .funct3     ( funct3     )
    , .zero       ( zero       )
    , .pc_update  ( pc_update  )
    , .ir_write   ( ir_write   )
    , .reg_write  ( reg_write  )
    , .mem_write  ( mem_write  )
    , .adr_src    ( adr_src    )
    , .alu_src_a  ( alu_src_a  )
    , .alu_src_b  ( alu_src_b  )
    , .result_src ( result_src )
    , .alu_mode   ( alu_mode   )
    );

  instr_decode i_instr_decode
    ( .instr    ( instr    )
    , .alu_mode ( alu_mode )
    , .opcode   ( opcode   )
    , .funct3   ( funct3   )
    , .rd       ( rd       )
    , .rs1      ( rs1      )
    , .rs2      ( rs2      )
    , .imm_ext  ( imm_ext  )
    , .alu_op   ( alu_op   )
    );

  reg_file i_reg_file
    ( .clk        ( clk       )
    , .rst_n      ( rst_n     )
    , .write_en   ( reg_write )
    , .rs1        ( rs1       )
    , .rs2        ( rs2       )
    , .rd         ( rd        )
    , .write_data ( result    )
    , .rd1        ( rd1       )
    , .rd2        ( rd2       )
    );

  alu i_alu
    ( .a      ( alu_a      )
    , .b      ( alu_b      )
    , .op     ( alu_op     )
    , .result ( alu_result )
    , .zero   ( zero       )
    );

  mem_access i_mem_access
    ( .address      ( mem_address      )
    , .read_data    ( mem_read_data    )
    , .store_data   ( data_b           )
    , .funct3       ( funct3           )
    , .mem_write    ( mem_write        )
    , .load_data    ( load_data        )
    , .write_data   ( mem_write_data   )
    , .write_enable ( mem_write_enable )
    );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (pc_update) begin
      pc <= result;
    end
  end

  always_ff @(posedge clk) begin
    if (ir_write) begin
      instr  <= mem_read_data;
      old_pc <= pc;  // Address of the instruction being fetched
    end
    data_reg <= load_data;
    data_a   <= rd1;
    data_b   <= rd2;
    alu_out  <= alu_result;
  end

  assign mem_address = (adr_src == ADR_RESULT) ? result : pc;

  always_comb begin
    case (alu_src_a)
      SRC_A_PC:     alu_a = pc;
      SRC_A_OLD_PC: alu_a = old_pc;
      SRC_A_RD1:    alu_a = data_a;
      default:      alu_a = '0;
    endcase
  end

  always_comb begin
    case (alu_src_b)
      SRC_B_RD2:     alu_b = data_b;
      SRC_B_IMM_EXT: alu_b = imm_ext;
      default:       alu_b = 32'd4;
    endcase
  end

  always_comb begin
    case (result_src)
      RES_ALU_OUT: result = alu_out;
      RES_DATA:    result = data_reg;
      default:     result = alu_result;
    endcase
  end

endmodule

`default_nettype wire

//--- source/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

module mem_access
  import riscv_isa_pkg::*;
  ( input  addr_t      address
  , input  data_t      read_data
  , input  data_t      store_data
  , input  logic [2:0] funct3
  , input  logic       mem_write
  , output data_t      load_data
  , output data_t      write_data
  , output logic [3:0] write_enable
  );

  logic [1:0] offset;
  logic [7:0] load_byte;

  assign offset = address[1:0];

  always_comb begin
    case (offset)
      2'd0:    load_byte = read_data[7:0];
      2'd1:    load_byte = read_data[15:8];
      2'd2:    load_byte = read_data[23:16];
      default: load_byte = read_data[31:24];
    endcase
  end

  always_comb begin
    case (funct3)
      F3_BYTE:   load_data = {{24{load_byte[7]}}, load_byte};
      F3_BYTE_U: load_data = {24'b0, load_byte};
      default:   load_data = read_data;  // lw
    endcase
  end

  // Byte goes out on every lane, the enable picks which one lands
  always_comb begin
    write_data   = store_data;
    write_enable = 4'b0000;
    if (mem_write) begin
      case (funct3)
        F3_BYTE: begin
          write_data   = {4{store_data[7:0]}};
          write_enable = 4'b0001 << offset;
        end
        default: write_enable = 4'b1111;  // sw
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
  import riscv_isa_pkg::*, core_ctrl_pkg::*;
  ( input  data_t   a
  , input  data_t   b
  , input  alu_op_t op
  , output data_t   result
  , output logic    zero
  );

  logic [4:0] shamt;

  assign shamt = b[4:0];  // Upper bits of the shift amount ignored

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLL: result = a << shamt;
      ALU_SRL: result = a >> shamt;
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import riscv_isa_pkg::*;
  ( input  logic       clk
  , input  logic       rst_n
  , input  logic       write_en
  , input  logic [4:0] rs1
  , input  logic [4:0] rs2
  , input  logic [4:0] rd
  , input  data_t      write_data
  , output data_t      rd1
  , output data_t      rd2
  );

  data_t regs [1:31];  // No storage behind x0

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && rd != 5'd0) begin
      regs[rd] <= write_data;
    end
  end

  assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- source/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode
  import riscv_isa_pkg::*, core_ctrl_pkg::*;
  ( input  instr_t     instr
  , input  alu_mode_t  alu_mode
  , output opcode_t    opcode
  , output logic [2:0] funct3
  , output logic [4:0] rd
  , output logic [4:0] rs1
  , output logic [4:0] rs2
  , output data_t      imm_ext
  , output alu_op_t    alu_op
  );

  logic funct7_b5;

  assign opcode    = opcode_t'(instr[6:0]);
  assign rd        = instr[11:7];
  assign funct3    = instr[14:12];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign funct7_b5 = instr[30];

  always_comb begin
    case (opcode)
      OP_STORE:  imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      OP_BRANCH: imm_ext = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
      OP_JAL:    imm_ext = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
      OP_LUI:    imm_ext = {instr[31:12], 12'b0};
      default:   imm_ext = {{20{instr[31]}}, instr[31:20]};  // I-type
    endcase
  end

  always_comb begin
    alu_op = ALU_ADD;
    case (alu_mode)
      MODE_SUB:   alu_op = ALU_SUB;
      MODE_FUNCT: begin
        case (funct3)
          // addi has no subtract form, bit 30 is immediate there
          F3_ADD_SUB: alu_op = (opcode == OP_R && funct7_b5) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL:     alu_op = ALU_SRL;
          F3_OR:      alu_op = ALU_OR;
          F3_AND:     alu_op = ALU_AND;
          default:    alu_op = ALU_ADD;
        endcase
      end
      default:    alu_op = ALU_ADD;
    endcase
  end

endmodule

`default_nettype wire

//--- source/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm
  import riscv_isa_pkg::*, core_ctrl_pkg::*;
  ( input  logic        clk
  , input  logic        rst_n
  , input  opcode_t     opcode
  , input  logic [2:0]  funct3
  , input  logic        zero
  , output logic        pc_update
  , output logic        ir_write
  , output logic        reg_write
  , output logic        mem_write
  , output adr_src_t    adr_src
  , output alu_src_a_t  alu_src_a
  , output alu_src_b_t  alu_src_b
  , output result_src_t result_src
  , output alu_mode_t   alu_mode
  );

  fsm_state_t state;
  fsm_state_t next_state;
  logic       started;  // Low for the first cycle after reset release

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= FETCH;
      started <= 1'b0;
    end else begin
      state   <= next_state;
      started <= 1'b1;
    end
  end

  always_comb begin
    next_state = FETCH;
    case (state)
      FETCH:     next_state = started ? DECODE : FETCH;
      DECODE: begin
        case (opcode)
          OP_R:      next_state = EXEC_R;
          OP_IMM:    next_state = EXEC_I;
          OP_LOAD:   next_state = MEM_ADR;
          OP_STORE:  next_state = MEM_ADR;
          OP_BRANCH: next_state = BRANCH;
          OP_JAL:    next_state = JAL;
          OP_LUI:    next_state = LUI;
          default:   next_state = FETCH;  // Unsupported opcode is skipped
        endcase
      end
      MEM_ADR:   next_state = (opcode == OP_LOAD) ? MEM_READ : MEM_WRITE;
      MEM_READ:  next_state = MEM_WB;
      EXEC_R:    next_state = ALU_WB;
      EXEC_I:    next_state = ALU_WB;
      JAL:       next_state = ALU_WB;
      LUI:       next_state = ALU_WB;
      default:   next_state = FETCH;
    endcase
  end

  always_comb begin
    pc_update  = 1'b0;
    ir_write   = 1'b0;
    reg_write  = 1'b0;
    mem_write  = 1'b0;
    adr_src    = ADR_PC;
    alu_src_a  = SRC_A_PC;
    alu_src_b  = SRC_B_FOUR;
    result_src = RES_ALU_RESULT;
    alu_mode   = MODE_ADD;
    case (state)
      FETCH: begin  // PC+4 straight back into the PC
        ir_write  = started;
        pc_update = started;
      end
      DECODE: begin  // Branch target into alu_out
        alu_src_a = SRC_A_OLD_PC;
        alu_src_b = SRC_B_IMM_EXT;
      end
      MEM_ADR: begin
        alu_src_a = SRC_A_RD1;
        alu_src_b = SRC_B_IMM_EXT;
      end
      MEM_READ: begin
        adr_src    = ADR_RESULT;
        result_src = RES_ALU_OUT;
      end
      MEM_WB: begin
        result_src = RES_DATA;
        reg_write  = 1'b1;
      end
      MEM_WRITE: begin
        adr_src    = ADR_RESULT;
        result_src = RES_ALU_OUT;
        mem_write  = 1'b1;
      end
      EXEC_R: begin
        alu_src_a = SRC_A_RD1;
        alu_src_b = SRC_B_RD2;
        alu_mode  = MODE_FUNCT;
      end
      EXEC_I: begin
        alu_src_a = SRC_A_RD1;
        alu_src_b = SRC_B_IMM_EXT;
        alu_mode  = MODE_FUNCT;
      end
      ALU_WB: begin
        result_src = RES_ALU_OUT;
        reg_write  = 1'b1;
      end
      BRANCH: begin
        alu_src_a  = SRC_A_RD1;
        alu_src_b  = SRC_B_RD2;
        alu_mode   = MODE_SUB;
        result_src = RES_ALU_OUT;
        case (funct3)
          F3_BEQ:  pc_update = zero;
          F3_BNE:  pc_update = !zero;
          default: pc_update = 1'b0;
        endcase
      end
      JAL: begin  // Target from DECODE into PC, link value into alu_out
        alu_src_a  = SRC_A_OLD_PC;
        result_src = RES_ALU_OUT;
        pc_update  = 1'b1;
      end
      LUI: begin
        alu_src_a = SRC_A_ZERO;
        alu_src_b = SRC_B_IMM_EXT;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- source/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [3:0] {
    FETCH     = 4'd0,
    DECODE    = 4'd1,
    MEM_ADR   = 4'd2,
    MEM_READ  = 4'd3,
    MEM_WB    = 4'd4,
    MEM_WRITE = 4'd5,
    EXEC_R    = 4'd6,
    EXEC_I    = 4'd7,
    ALU_WB    = 4'd8,
    BRANCH    = 4'd9,
    JAL       = 4'd10,
    LUI       = 4'd11
  } fsm_state_t;

  typedef enum logic {
    ADR_PC     = 1'b0,
    ADR_RESULT = 1'b1
  } adr_src_t;

  typedef enum logic [1:0] {
    SRC_A_PC     = 2'd0,
    SRC_A_OLD_PC = 2'd1,
    SRC_A_RD1    = 2'd2,
    SRC_A_ZERO   = 2'd3
  } alu_src_a_t;

  typedef enum logic [1:0] {
    SRC_B_RD2     = 2'd0,
    SRC_B_IMM_EXT = 2'd1,
    SRC_B_FOUR    = 2'd2
  } alu_src_b_t;

  typedef enum logic [1:0] {
    RES_ALU_OUT    = 2'd0,
    RES_DATA       = 2'd1,
    RES_ALU_RESULT = 2'd2
  } result_src_t;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    MODE_ADD   = 2'd0,  // Address and PC arithmetic
    MODE_SUB   = 2'd1,  // Branch compare
    MODE_FUNCT = 2'd2   // Taken from funct3/funct7
  } alu_mode_t;

endpackage

`default_nettype wire

//--- source/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // Only the major opcodes this core executes
  typedef enum logic [6:0] {
    OP_R      = 7'b0110011,
    OP_IMM    = 7'b0010011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_LUI    = 7'b0110111
  } opcode_t;

  // ALU group
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL     = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Load and store widths
  localparam logic [2:0] F3_BYTE    = 3'b000;
  localparam logic [2:0] F3_WORD    = 3'b010;
  localparam logic [2:0] F3_BYTE_U  = 3'b100;

  // Branch conditions
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam addr_t RESET_PC = 32'h0000_0000;  // First fetch address

endpackage

`default_nettype wire
